//--- hdl/uart_pkg.sv
`default_nettype none
// ==========================================================
// Serial timing and frame constants for both UART directions
// Rates are the simulation values; divisor must fit 8 bits
// ==========================================================

package uart_pkg;

    localparam int clock_hz       = 1000;
    localparam int baud           = 100;
    localparam int baud_cnt_width = 8;
    localparam logic [baud_cnt_width-1:0] divisor      = baud_cnt_width'(clock_hz / baud);
    localparam logic [baud_cnt_width-1:0] half_divisor = divisor >> 1;  // Delay to mid-bit
    localparam int data_bits      = 8;                                  // 8N1 payload

    typedef logic [data_bits-1:0] byte_t;

endpackage

`default_nettype wire

//--- hdl/proto_pkg.sv
`default_nettype none
// ==========================================================
// Text protocol definitions
// Report line is fixed, no sequence number is sent
// Durations wrap at 24 bits
// ==========================================================

package proto_pkg;

    // ASCII codes used by the parser
    localparam uart_pkg::byte_t char_a       = 8'h41;
    localparam uart_pkg::byte_t char_c       = 8'h43;
    localparam uart_pkg::byte_t char_k       = 8'h4b;
    localparam uart_pkg::byte_t char_space   = 8'h20;
    localparam uart_pkg::byte_t char_newline = 8'h0a;
    localparam uart_pkg::byte_t char_zero    = 8'h30;
    localparam uart_pkg::byte_t char_nine    = 8'h39;

    // "BTN 1" plus newline
    localparam int report_len = 6;
    localparam uart_pkg::byte_t report_text [0:report_len-1] = '{
        8'h42, 8'h54, 8'h4e, char_space, 8'h31, char_newline
    };

    localparam int duration_width = 24;

    typedef logic [duration_width-1:0] duration_t;

endpackage

`default_nettype wire

//--- hdl/uart_tx.sv
// ==========================================================
// 8N1 transmitter, LSB first, tx idles high
// Busy lasts exactly 10 bit times from the cycle after start
// Start must only arrive while busy is low
// ==========================================================
`timescale 1ns/10ps
`default_nettype none

module uart_tx (
    input  logic            clk,
    input  logic            rst,
    input  uart_pkg::byte_t tx_data,
    input  logic            tx_start,
    output logic            tx_busy,
    output logic            tx
);

    logic [uart_pkg::baud_cnt_width-1:0] baud_cnt;
    logic [3:0]                          bit_idx;   // 0 start, 1-8 data, 9 stop
    uart_pkg::byte_t                     shifter;

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_busy  <= 1'b0;
            tx       <= 1'b1;
            baud_cnt <= '0;
            bit_idx  <= '0;
        end else if (!tx_busy) begin
            tx <= 1'b1;
            if (tx_start) begin
                tx_busy  <= 1'b1;
                tx       <= 1'b0;                       // Start bit
                shifter  <= tx_data;
                baud_cnt <= uart_pkg::divisor - 1'b1;
                bit_idx  <= '0;
            end
        end else if (baud_cnt != '0) begin
            baud_cnt <= baud_cnt - 1'b1;
        end else if (bit_idx == 4'(uart_pkg::data_bits + 1)) begin
            tx_busy <= 1'b0;                            // End of stop bit
        end else begin
            // Next bit: data while shifting, then stop
            baud_cnt <= uart_pkg::divisor - 1'b1;
            bit_idx  <= bit_idx + 4'd1;
            tx       <= (bit_idx < 4'(uart_pkg::data_bits)) ? shifter[0] : 1'b1;
            shifter  <= shifter >> 1;
        end
    end

    // Sender must wait for the previous frame to finish
    start_while_idle_a: assert property (@(posedge clk) disable iff (rst)
        tx_start |-> !tx_busy);

endmodule

`default_nettype wire

//--- hdl/uart_rx.sv
// ==========================================================
// 8N1 receiver with mid-bit sampling, no input synchronizer
// A frame with a low stop bit is dropped without notice
// Valid pulses near the end of the stop bit
// ==========================================================
`timescale 1ns/10ps
`default_nettype none

module uart_rx (
    input  logic            clk,
    input  logic            rst,
    input  logic            rx,
    output uart_pkg::byte_t rx_data,
    output logic            rx_valid
);

    logic [uart_pkg::baud_cnt_width-1:0] baud_cnt;
    logic [3:0]                          bit_idx;    // 0 start, 1-8 data, 9 stop, 10 tail
    uart_pkg::byte_t                     shifter;
    logic                                busy;
    logic                                frame_done;

    // Half-bit tail after a good stop bit has run out
    assign frame_done = busy && baud_cnt == '0 && bit_idx == 4'(uart_pkg::data_bits + 2);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            baud_cnt <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= frame_done;
            if (!busy || frame_done) begin
                // Low level opens a new frame
                busy     <= !rx;
                baud_cnt <= uart_pkg::half_divisor - 1'b1;
                bit_idx  <= '0;
            end else if (baud_cnt != '0) begin
                baud_cnt <= baud_cnt - 1'b1;
            end else begin
                baud_cnt <= uart_pkg::divisor - 1'b1;
                bit_idx  <= bit_idx + 4'd1;
                if (bit_idx == '0) begin
                    busy <= !rx;                        // Glitch, not a start bit
                end else if (bit_idx <= 4'(uart_pkg::data_bits)) begin
                    shifter <= {rx, shifter[uart_pkg::data_bits-1:1]};
                end else begin
                    // Stop bit
                    busy     <= rx;
                    baud_cnt <= uart_pkg::half_divisor - 1'b1;
                    if (rx) begin
                        rx_data <= shifter;
                    end
                end
            end
        end
    end

    valid_single_cycle_a: assert property (@(posedge clk) disable iff (rst)
        rx_valid |=> !rx_valid);

endmodule

`default_nettype wire

//--- hdl/report_sender.sv
// ==========================================================
// Sends the fixed report line once per button press
// Button is active low with no debounce
// Presses during a report are ignored
// ==========================================================
`timescale 1ns/10ps
`default_nettype none

module report_sender (
    input  logic            clk,
    input  logic            rst,
    input  logic            btn_n,
    input  logic            tx_busy,
    output uart_pkg::byte_t tx_data,
    output logic            tx_start
);

    logic       btn_q;
    logic       btn_prev;
    logic       busy_q;
    logic       active;     // Report in flight
    logic [2:0] char_idx;
    logic       press;
    logic       busy_fall;

    assign press     = btn_q && !btn_prev;
    assign busy_fall = busy_q && !tx_busy;  // Previous character done

    always_ff @(posedge clk) begin
        if (rst) begin
            btn_q    <= 1'b0;
            btn_prev <= 1'b0;
            busy_q   <= 1'b0;
            active   <= 1'b0;
            char_idx <= '0;
            tx_start <= 1'b0;
        end else begin
            btn_q    <= !btn_n;
            btn_prev <= btn_q;
            busy_q   <= tx_busy;
            tx_start <= 1'b0;
            if (!active) begin
                if (press) begin
                    active   <= 1'b1;
                    char_idx <= '0;
                    tx_data  <= proto_pkg::report_text[0];
                    tx_start <= 1'b1;
                end
            end else if (busy_fall) begin
                if (char_idx == 3'(proto_pkg::report_len - 1)) begin
                    active <= 1'b0;                     // Newline sent
                end else begin
                    char_idx <= char_idx + 3'd1;
                    tx_data  <= proto_pkg::report_text[char_idx + 3'd1];
                    tx_start <= 1'b1;
                end
            end
        end
    end

    index_in_range_a: assert property (@(posedge clk) disable iff (rst)
        int'(char_idx) < proto_pkg::report_len);

endmodule

`default_nettype wire

//--- hdl/ack_parser.sv
// ==========================================================
// Parses "ACK" space digits newline into a cycle count
// No digits gives a count of zero, large values wrap
// Any unexpected character drops the line
// ==========================================================
`timescale 1ns/10ps
`default_nettype none

module ack_parser (
    input  logic                 clk,
    input  logic                 rst,
    input  uart_pkg::byte_t      rx_data,
    input  logic                 rx_valid,
    output logic                 ack_trigger,
    output proto_pkg::duration_t ack_cycles
);

    enum logic [2:0] {
        st_idle,
        st_got_a,
        st_got_c,
        st_got_k,
        st_got_space,
        st_in_number
    } state;

    logic                 is_digit;
    proto_pkg::duration_t digit_val;
    proto_pkg::duration_t value;     // Running decimal value

    assign is_digit  = rx_data >= proto_pkg::char_zero && rx_data <= proto_pkg::char_nine;
    assign digit_val = proto_pkg::duration_t'(rx_data - proto_pkg::char_zero);

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= st_idle;
            ack_trigger <= 1'b0;
        end else begin
            ack_trigger <= 1'b0;
            if (rx_valid) begin
                state <= st_idle;
                case (state)
                    st_idle:  if (rx_data == proto_pkg::char_a)     state <= st_got_a;
                    st_got_a: if (rx_data == proto_pkg::char_c)     state <= st_got_c;
                    st_got_c: if (rx_data == proto_pkg::char_k)     state <= st_got_k;
                    st_got_k: if (rx_data == proto_pkg::char_space) state <= st_got_space;
                    st_got_space, st_in_number: begin
                        if (is_digit) begin
                            // value * 10 + digit
                            value <= (state == st_in_number) ?
                                     (value << 3) + (value << 1) + digit_val : digit_val;
                            state <= st_in_number;
                        end else if (rx_data == proto_pkg::char_newline) begin
                            ack_cycles  <= (state == st_in_number) ? value : '0;
                            ack_trigger <= 1'b1;
                        end
                    end
                    default: state <= st_idle;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/led_timer.sv
// ==========================================================
// LED on-time counter, a new trigger reloads the count
// A zero load keeps the LED off
// ==========================================================
`timescale 1ns/10ps
`default_nettype none

module led_timer (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 ack_trigger,
    input  proto_pkg::duration_t ack_cycles,
    output logic                 led
);

    proto_pkg::duration_t count;   // Cycles still to light

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
            led   <= 1'b0;
        end else if (ack_trigger) begin
            count <= ack_cycles;
            led   <= ack_cycles != '0;
        end else if (count != '0) begin
            count <= count - 1'b1;
            led   <= count != proto_pkg::duration_t'(1);  // Last lit cycle
        end
    end

    led_matches_count_a: assert property (@(posedge clk) disable iff (rst)
        led == (count != '0));

endmodule

`default_nettype wire

//--- hdl/super_counter.sv
// ==========================================================
// UART button reporter with LED acknowledgment
// Button press sends "BTN 1" line, ACK line lights the LED
// ==========================================================
`timescale 1ns/10ps
`default_nettype none

module super_counter (
    input  logic clk,
    input  logic rst,
    input  logic btn_n,
    input  logic rx,
    output logic tx,
    output logic led
);

    // ==========================================================
    // Transmit chain
    // ==========================================================
    uart_pkg::byte_t tx_data;
    logic            tx_start;
    logic            tx_busy;

    report_sender u_report_sender (
        .clk      (clk),
        .rst      (rst),
        .btn_n    (btn_n),
        .tx_busy  (tx_busy),
        .tx_data  (tx_data),
        .tx_start (tx_start)
    );

    uart_tx u_uart_tx (
        .clk      (clk),
        .rst      (rst),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .tx_busy  (tx_busy),
        .tx       (tx)
    );

    // ==========================================================
    // Receive chain
    // ==========================================================
    uart_pkg::byte_t      rx_data;
    logic                 rx_valid;
    logic                 ack_trigger;
    proto_pkg::duration_t ack_cycles;

    uart_rx u_uart_rx (
        .clk      (clk),
        .rst      (rst),
        .rx       (rx),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    ack_parser u_ack_parser (
        .clk         (clk),
        .rst         (rst),
        .rx_data     (rx_data),
        .rx_valid    (rx_valid),
        .ack_trigger (ack_trigger),
        .ack_cycles  (ack_cycles)
    );

    led_timer u_led_timer (
        .clk         (clk),
        .rst         (rst),
        .ack_trigger (ack_trigger),
        .ack_cycles  (ack_cycles),
        .led         (led)
    );

endmodule

`default_nettype wire

//--- testbench/tb_checker.sv
// ==========================================================
// Watches tx and led of the reporter
// Frames are decoded on falling clock edges, LSB first
// Expected LED lengths arrive from the top in order
// ==========================================================
`timescale 1ns/10ps
`default_nettype none

module tb_checker (
    input  logic clk,
    input  logic rst,
    input  logic tx,
    input  logic led,
    input  logic quiet,
    input  logic exp_push,
    input  int   exp_len,
    input  logic end_check,
    input  int   exp_reports,
    output int   bytes_seen,
    output int   pulses_seen,
    output int   frame_errors,
    output int   pulse_errors,
    output int   count_errors
);

    localparam int bit_cycles   = int'(uart_pkg::divisor);
    localparam int half_bit     = bit_cycles / 2;
    localparam int report_bytes = 6;
    localparam logic [8*report_bytes-1:0] report_chars = {"BTN 1", 8'h0a};

    int expected_len [$];
    int high_cycles;
    int want_len;

    // ==========================================================
    // Frame decoder
    // ==========================================================
    task automatic decode_frame();
        uart_pkg::byte_t data;
        uart_pkg::byte_t want;
        logic            stop;
        repeat (half_bit) @(negedge clk);
        if (tx !== 1'b0) begin
            $display("[ERROR] %0t: tx start bit not low at mid-bit", $time);
            frame_errors++;
        end else begin
            for (int i = 0; i < 8; i++) begin
                repeat (bit_cycles) @(negedge clk);
                data[i] = tx;
            end
            repeat (bit_cycles) @(negedge clk);
            stop = tx;
            want = report_chars[8*(report_bytes - 1 - bytes_seen % report_bytes) +: 8];
            if (stop !== 1'b1) begin
                $display("[ERROR] %0t: tx stop bit low in byte %0d", $time, bytes_seen);
                frame_errors++;
            end
            if (data !== want) begin
                $display("[ERROR] %0t: tx byte %0d is 0x%02h, expected 0x%02h",
                         $time, bytes_seen, data, want);
                frame_errors++;
            end
            bytes_seen++;
        end
    endtask

    initial begin
        bytes_seen   = 0;
        frame_errors = 0;
        forever begin
            @(negedge clk);
            if (!rst && tx === 1'b0) begin
                decode_frame();
            end
        end
    end

    // ==========================================================
    // LED pulse measurement and end checks
    // ==========================================================
    always @(negedge clk) begin
        if (rst) begin
            expected_len.delete();
            high_cycles  = 0;
            pulses_seen  = 0;
            pulse_errors = 0;
            count_errors = 0;
        end else begin
            if (exp_push) begin
                expected_len.push_back(exp_len);
            end
            if (quiet && (tx !== 1'b1 || led !== 1'b0)) begin
                $display("[ERROR] %0t: outputs not idle, tx %b led %b", $time, tx, led);
                count_errors++;
            end
            if (led === 1'b1) begin
                high_cycles++;
            end else if (high_cycles != 0) begin
                if (expected_len.size() == 0) begin
                    $display("[ERROR] %0t: unexpected LED pulse of %0d cycles",
                             $time, high_cycles);
                    pulse_errors++;
                end else begin
                    want_len = expected_len.pop_front();
                    if (want_len != high_cycles) begin
                        $display("[ERROR] %0t: LED high for %0d cycles, expected %0d",
                                 $time, high_cycles, want_len);
                        pulse_errors++;
                    end
                end
                pulses_seen++;
                high_cycles = 0;
            end
            if (end_check) begin
                if (bytes_seen != report_bytes * exp_reports) begin
                    $display("[ERROR] %0t: %0d tx bytes seen, expected %0d",
                             $time, bytes_seen, report_bytes * exp_reports);
                    count_errors++;
                end
                if (expected_len.size() != 0) begin
                    $display("[ERROR] %0t: %0d LED pulses never seen",
                             $time, expected_len.size());
                    count_errors++;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- testbench/tb_super_counter.sv
// ==========================================================
// Testbench top for the UART button reporter
// Cases come from testbench/super_counter_cases.txt
// Idle gaps between cases use an xorshift with a fixed seed
// ==========================================================
`timescale 1ns/10ps
`default_nettype none

module tb_super_counter;

    localparam int bit_cycles   = int'(uart_pkg::divisor);
    localparam int frame_cycles = 10 * bit_cycles;
    localparam int report_bytes = 6;
    localparam int max_gap      = 30;
    localparam int quiet_cycles = 20;
    localparam int kind_press   = 0;
    localparam int kind_line    = 1;
    localparam int kind_reload  = 2;

    logic clk;
    logic rst;
    logic btn_n;
    logic rx;
    logic tx;
    logic led;

    logic exp_push;
    int   exp_len;
    logic quiet;
    logic end_check;
    int   exp_reports;
    int   bytes_seen;
    int   pulses_seen;
    int   frame_errors;
    int   pulse_errors;
    int   count_errors;

    int              case_kind   [$];
    int              case_hold   [$];
    logic [8*16-1:0] case_text_a [$];
    logic [8*16-1:0] case_text_b [$];
    int              case_expect [$];

    int          cycle_count = 0;
    int          cycle_limit = 0;
    int          read_errors = 0;
    int          pulses_expected;
    logic [31:0] rng_state;

    super_counter i_dut (
        .clk   (clk),
        .rst   (rst),
        .btn_n (btn_n),
        .rx    (rx),
        .tx    (tx),
        .led   (led)
    );

    tb_checker i_checker (
        .clk          (clk),
        .rst          (rst),
        .tx           (tx),
        .led          (led),
        .quiet        (quiet),
        .exp_push     (exp_push),
        .exp_len      (exp_len),
        .end_check    (end_check),
        .exp_reports  (exp_reports),
        .bytes_seen   (bytes_seen),
        .pulses_seen  (pulses_seen),
        .frame_errors (frame_errors),
        .pulse_errors (pulse_errors),
        .count_errors (count_errors)
    );

    always #50 clk = ~clk;  // 100 ns period

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cycle_count);
            $display("test failed");
            $finish;
        end
    end

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int text_len(input logic [8*16-1:0] t);
        int n;
        n = 0;
        for (int i = 0; i < 16; i++) begin
            if (t[8*i +: 8] != 8'h00) begin
                n++;
            end
        end
        return n;
    endfunction

    // ==========================================================
    // Stimulus tasks, all resume 1 ns after a rising edge
    // ==========================================================
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic send_byte(input uart_pkg::byte_t b);
        logic [9:0] bits;
        bits = {1'b1, b, 1'b0};     // Stop, data, start
        for (int i = 0; i < 10; i++) begin
            rx = bits[i];
            wait_cycles(bit_cycles);
        end
    endtask

    task automatic send_text(input logic [8*16-1:0] t);
        uart_pkg::byte_t c;
        for (int i = 15; i >= 0; i--) begin
            c = t[8*i +: 8];
            if (c != 8'h00) begin
                send_byte((c == "_") ? 8'h20 : c);
            end
        end
        send_byte(8'h0a);
    endtask

    task automatic press_button(input int hold);
        btn_n = 1'b0;
        wait_cycles(hold);
        btn_n = 1'b1;
    endtask

    task automatic expect_pulse(input int n);
        exp_len  = n;
        exp_push = 1'b1;
        wait_cycles(1);
        exp_push = 1'b0;
        pulses_expected++;
    endtask

    task automatic wait_reports(input int n);
        while (bytes_seen < report_bytes * n) begin
            wait_cycles(1);
        end
        wait_cycles(bit_cycles);    // Rest of the last stop bit
    endtask

    task automatic wait_pulses(input int n);
        while (pulses_seen < n) begin
            wait_cycles(1);
        end
    endtask

    task automatic read_cases();
        int              fd;
        int              n;
        int              c;
        int              hold;
        int              expect_val;
        logic [8*16-1:0] kind;
        logic [8*16-1:0] text_a;
        logic [8*16-1:0] text_b;
        cycle_limit = 3 + quiet_cycles + 2 * frame_cycles + 500;
        fd = $fopen("testbench/super_counter_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file testbench/super_counter_cases.txt");
            read_errors++;
        end else begin
            n = $fscanf(fd, "%s", kind);
            while (n == 1) begin
                if (kind == "#") begin
                    c = $fgetc(fd);
                    while (c != 10 && c != -1) begin
                        c = $fgetc(fd);
                    end
                end else if (kind == "press") begin
                    n = $fscanf(fd, "%d %d", hold, expect_val);
                    case_kind.push_back(kind_press);
                    case_hold.push_back(hold);
                    case_text_a.push_back('0);
                    case_text_b.push_back('0);
                    case_expect.push_back(expect_val);
                    cycle_limit += hold + max_gap + 2 * bit_cycles
                                   + expect_val * report_bytes * frame_cycles;
                end else if (kind == "line") begin
                    n = $fscanf(fd, "%s %d", text_a, expect_val);
                    case_kind.push_back(kind_line);
                    case_hold.push_back(0);
                    case_text_a.push_back(text_a);
                    case_text_b.push_back('0);
                    case_expect.push_back(expect_val);
                    cycle_limit += (text_len(text_a) + 1) * frame_cycles + expect_val + max_gap;
                end else if (kind == "reload") begin
                    n = $fscanf(fd, "%s %s %d", text_a, text_b, expect_val);
                    case_kind.push_back(kind_reload);
                    case_hold.push_back(0);
                    case_text_a.push_back(text_a);
                    case_text_b.push_back(text_b);
                    case_expect.push_back(expect_val);
                    cycle_limit += (text_len(text_a) + text_len(text_b) + 2) * frame_cycles
                                   + expect_val + max_gap;
                end else begin
                    $display("Unknown case kind in the case file: %0s", kind);
                    read_errors++;
                end
                n = $fscanf(fd, "%s", kind);
            end
            $fclose(fd);
        end
    endtask

    // ==========================================================
    // Main sequence
    // ==========================================================
    initial begin
        int gap;
        int total;
        clk             = 1'b0;
        rst             = 1'b1;
        btn_n           = 1'b1;
        rx              = 1'b1;
        exp_push        = 1'b0;
        exp_len         = 0;
        quiet           = 1'b1;
        end_check       = 1'b0;
        exp_reports     = 0;
        pulses_expected = 0;
        rng_state       = 32'd75643;
        read_cases();
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        wait_cycles(quiet_cycles);  // tx high, led low
        quiet = 1'b0;
        foreach (case_kind[i]) begin
            rng_state = next_random(rng_state);
            gap = int'(rng_state % 32'd31);
            wait_cycles(gap);
            if (case_kind[i] == kind_press) begin
                if (case_expect[i] > 0) begin
                    wait_reports(exp_reports);  // Sender must be idle again
                end
                exp_reports += case_expect[i];
                press_button(case_hold[i]);
            end else begin
                if (case_expect[i] > 0) begin
                    expect_pulse(case_expect[i]);
                end
                send_text(case_text_a[i]);
                if (case_kind[i] == kind_reload) begin
                    send_text(case_text_b[i]);  // Back to back, reloads while lit
                end
                wait_pulses(pulses_expected);
            end
        end
        wait_reports(exp_reports);
        wait_pulses(pulses_expected);
        wait_cycles(2 * frame_cycles);  // Room for stray frames or pulses
        end_check = 1'b1;
        wait_cycles(1);
        end_check = 1'b0;
        wait_cycles(1);
        total = frame_errors + pulse_errors + count_errors + read_errors;
        $display("Errors: frame %0d, pulse %0d, count %0d, case file %0d",
                 frame_errors, pulse_errors, count_errors, read_errors);
        if (total == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
hdl/uart_pkg.sv
hdl/proto_pkg.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/report_sender.sv
hdl/ack_parser.sv
hdl/led_timer.sv
hdl/super_counter.sv
testbench/tb_checker.sv
testbench/tb_super_counter.sv

//--- Makefile
# Verilator build and run for the UART button reporter

VERILATOR ?= verilator
TOP       ?= tb_super_counter
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(BUILD_DIR)

//--- testbench/super_counter_cases.txt
# press  hold_cycles  expected_reports
# line   text (_ is a space, newline appended)  expected_led_cycles
# reload first_text  second_text  expected_total_led_cycles
press 12 1
press 8 0
press 20 1
line ACK_37 37
line ACK_1234 1234
line ACX_5 0
line ACK_5x 0
line ACK5 0
line ACK_ 0
line ACK_0 0
line ACK_16777218 2
line ACK_9 9
reload ACK_2000 ACK_50 750
